// ==== common/mem_pkg.sv ====
/*
 * Shared constants for the memory subsystem.
 * MEM_BYTES must equal 4 * MEM_WORDS, with MEM_WORDS = 2**WORD_ADDR_W.
 * QPTR_W and QCNT_W must fit QUEUE_DEPTH; META_PTR_W must fit META_DEPTH.
 */
`default_nettype none

package mem_pkg;

    // RAM geometry
    localparam logic [31:0] MEM_BASE    = 32'h0000_0000;  // Byte address of first RAM byte
    localparam logic [31:0] MEM_BYTES   = 32'd16384;      // Size in bytes
    localparam int          MEM_WORDS   = 4096;           // Size in 32-bit words
    localparam int          WORD_ADDR_W = 12;             // Word index width

    // Request queues
    localparam int QUEUE_DEPTH = 2;                       // Entries per port, credits at reset
    localparam int QPTR_W      = 1;                       // Queue pointer width
    localparam int QCNT_W      = 2;                       // Queue fill count width

    // Load/store side FIFO, covers queue plus two pipeline stages in flight
    localparam int META_DEPTH  = QUEUE_DEPTH + 2;
    localparam int META_PTR_W  = 2;

    // RV32 funct3 access codes, loads and stores told apart by we
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

endpackage

`default_nettype wire

// ==== hw/req_queue.sv ====
/*
 * Circular request FIFO of QUEUE_DEPTH entries.
 * No full check: the credit rule keeps pushes within capacity.
 * credit is pop delayed by one cycle, one pulse per entry leaving.
 */
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int ENTRY_W = 8
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               push,
    input  logic [ENTRY_W-1:0] push_entry,
    input  logic               pop,
    output logic               valid,
    output logic [ENTRY_W-1:0] head,
    output logic               credit
);
    import mem_pkg::*;

    logic [ENTRY_W-1:0] entries [QUEUE_DEPTH];  // Payload storage
    logic [QPTR_W-1:0]  wr_ptr;
    logic [QPTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0]  count;                  // Entries held

    assign valid = (count != '0);
    assign head  = entries[rd_ptr];             // Head shown while valid

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle or push and pop together
            endcase
            credit <= pop;                      // Credit back one cycle after grant
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_port.sv ====
/*
 * Instruction fetch front end. Word accesses only.
 * Unaligned or out-of-range fetches are queued as faults and
 * return data 0 with fault set. Responses come back in order.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_port (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          fetch_valid,
    input  logic [31:0]                   fetch_addr,
    output logic                          fetch_credit,
    output logic                          q_valid,
    output logic [mem_pkg::WORD_ADDR_W-1:0] q_word_idx,
    output logic                          q_fault,
    input  logic                          q_pop,
    input  logic                          rd_valid,
    input  logic [31:0]                   rd_word,
    input  logic                          rd_fault,
    output logic                          fetch_rsp_valid,
    output logic [31:0]                   fetch_rsp_data,
    output logic                          fetch_rsp_fault
);
    import mem_pkg::*;

    logic [31:0]          offset;                // Byte offset into RAM
    logic                 req_fault;
    logic [WORD_ADDR_W:0] req_entry;             // {fault, word index}
    logic [WORD_ADDR_W:0] head_entry;

    assign offset    = fetch_addr - MEM_BASE;
    assign req_fault = (offset >= MEM_BYTES) || (fetch_addr[1:0] != 2'b00);
    assign req_entry = {req_fault, offset[WORD_ADDR_W+1:2]};

    req_queue #(.ENTRY_W(WORD_ADDR_W + 1)) u_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .push       (fetch_valid),
        .push_entry (req_entry),
        .pop        (q_pop),
        .valid      (q_valid),
        .head       (head_entry),
        .credit     (fetch_credit)
    );

    assign {q_fault, q_word_idx} = head_entry;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fetch_rsp_valid <= 1'b0;
        end else begin
            fetch_rsp_valid <= rd_valid;
        end
    end

    always_ff @(posedge clock) begin
        fetch_rsp_data  <= rd_fault ? 32'd0 : rd_word;   // Faulted fetch reads as 0
        fetch_rsp_fault <= rd_fault;
    end

endmodule

`default_nettype wire

// ==== hw/lsu_port.sv ====
/*
 * Load/store front end using RV32 funct3 codes.
 * Misaligned, out-of-range or unknown-size accesses are queued as faults.
 * Stores and faults respond with data 0. Loads are sign or zero extended.
 */
`timescale 1ns/1ps
`default_nettype none

module lsu_port (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          data_valid,
    input  logic                          data_we,
    input  logic [2:0]                    data_funct3,
    input  logic [31:0]                   data_addr,
    input  logic [31:0]                   data_wdata,
    output logic                          data_credit,
    output logic                          q_valid,
    output logic [mem_pkg::WORD_ADDR_W-1:0] q_word_idx,
    output logic [3:0]                    q_be,
    output logic [31:0]                   q_wdata,
    output logic                          q_fault,
    input  logic                          q_pop,
    input  logic                          rd_valid,
    input  logic [31:0]                   rd_word,
    input  logic                          rd_fault,
    output logic                          data_rsp_valid,
    output logic [31:0]                   data_rsp_rdata,
    output logic                          data_rsp_fault
);
    import mem_pkg::*;

    localparam int ENTRY_W = WORD_ADDR_W + 37;   // fault, index, be, wdata

    logic [31:0]        offset;
    logic [1:0]         acc_size;                // 0 byte, 1 half, 2 word, 3 illegal
    logic [3:0]         lane_be;
    logic               misalign;
    logic               req_fault;
    logic [ENTRY_W-1:0] req_entry;
    logic [ENTRY_W-1:0] head_entry;

    logic [5:0]            meta_mem [META_DEPTH]; // {we, funct3, addr[1:0]}
    logic [META_PTR_W-1:0] meta_wr;
    logic [META_PTR_W-1:0] meta_rd;
    logic                  m_we;
    logic [2:0]            m_funct3;
    logic [1:0]            m_off;
    logic [31:0]           rd_shift;             // Addressed lane moved to bit 0
    logic [31:0]           load_data;

    assign offset = data_addr - MEM_BASE;

    always_comb begin
        if (data_we) begin
            case (data_funct3)
                F3_SB:   acc_size = 2'd0;
                F3_SH:   acc_size = 2'd1;
                F3_SW:   acc_size = 2'd2;
                default: acc_size = 2'd3;        // No unsigned store
            endcase
        end else begin
            case (data_funct3)
                F3_LB, F3_LBU: acc_size = 2'd0;
                F3_LH, F3_LHU: acc_size = 2'd1;
                F3_LW:         acc_size = 2'd2;
                default:       acc_size = 2'd3;
            endcase
        end
    end

    always_comb begin
        case (acc_size)
            2'd0: begin
                lane_be  = 4'b0001 << data_addr[1:0];
                misalign = 1'b0;
            end
            2'd1: begin
                lane_be  = 4'b0011 << {data_addr[1], 1'b0};
                misalign = data_addr[0];
            end
            2'd2: begin
                lane_be  = 4'b1111;
                misalign = (data_addr[1:0] != 2'b00);
            end
            default: begin
                lane_be  = 4'b0000;
                misalign = 1'b1;                 // Illegal size faults like misalign
            end
        endcase
    end

    assign req_fault = (offset >= MEM_BYTES) || misalign;
    // Loads and faults carry no lanes, RAM sees a read or nothing
    assign req_entry = {req_fault, offset[WORD_ADDR_W+1:2],
                        (data_we && !req_fault) ? lane_be : 4'b0000,
                        data_wdata << {data_addr[1:0], 3'b000}};

    req_queue #(.ENTRY_W(ENTRY_W)) u_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .push       (data_valid),
        .push_entry (req_entry),
        .pop        (q_pop),
        .valid      (q_valid),
        .head       (head_entry),
        .credit     (data_credit)
    );

    assign {q_fault, q_word_idx, q_be, q_wdata} = head_entry;

    // Side FIFO, pushed with each request, popped with each RAM return
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            meta_wr <= '0;
            meta_rd <= '0;
        end else begin
            if (data_valid) begin
                meta_wr <= (meta_wr == META_PTR_W'(META_DEPTH - 1)) ? '0 : meta_wr + 1'b1;
            end
            if (rd_valid) begin
                meta_rd <= (meta_rd == META_PTR_W'(META_DEPTH - 1)) ? '0 : meta_rd + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (data_valid) begin
            meta_mem[meta_wr] <= {data_we, data_funct3, data_addr[1:0]};
        end
    end

    assign {m_we, m_funct3, m_off} = meta_mem[meta_rd];
    assign rd_shift = rd_word >> {m_off, 3'b000};

    always_comb begin
        case (m_funct3)
            F3_LB:   load_data = {{24{rd_shift[7]}}, rd_shift[7:0]};
            F3_LBU:  load_data = {24'd0, rd_shift[7:0]};
            F3_LH:   load_data = {{16{rd_shift[15]}}, rd_shift[15:0]};
            F3_LHU:  load_data = {16'd0, rd_shift[15:0]};
            F3_LW:   load_data = rd_shift;        // Offset is 0 when aligned
            default: load_data = 32'd0;
        endcase
        if (m_we || rd_fault) begin
            load_data = 32'd0;                    // Stores and faults read as 0
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            data_rsp_valid <= 1'b0;
        end else begin
            data_rsp_valid <= rd_valid;
        end
    end

    always_ff @(posedge clock) begin
        data_rsp_rdata <= load_data;
        data_rsp_fault <= rd_fault;
    end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter_ram.sv ====
/*
 * Shared byte-lane RAM with an alternating two-port arbiter.
 * One grant per cycle. Memory contents are undefined after power-up.
 * Every grant returns rd_valid two edges later. Stores and faults leave rd_word stale.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_ram (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          f_valid,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] f_word_idx,
    input  logic                          f_fault,
    input  logic                          d_valid,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] d_word_idx,
    input  logic [3:0]                    d_be,
    input  logic [31:0]                   d_wdata,
    input  logic                          d_fault,
    output logic                          f_pop,
    output logic                          d_pop,
    output logic                          f_rd_valid,
    output logic [31:0]                   f_rd_word,
    output logic                          f_rd_fault,
    output logic                          d_rd_valid,
    output logic [31:0]                   d_rd_word,
    output logic                          d_rd_fault
);
    import mem_pkg::*;

    logic [7:0] mem_b0 [MEM_WORDS];              // One array per byte lane
    logic [7:0] mem_b1 [MEM_WORDS];
    logic [7:0] mem_b2 [MEM_WORDS];
    logic [7:0] mem_b3 [MEM_WORDS];

    logic                   turn_data;           // Data port wins a tie
    logic                   s_valid;             // Granted access stage
    logic                   s_data;              // Owner, 1 for data port
    logic [WORD_ADDR_W-1:0] s_idx;
    logic [3:0]             s_be;                // Nonzero means store
    logic [31:0]            s_wdata;
    logic                   s_fault;
    logic                   ram_wr;
    logic                   ram_rd;
    logic [31:0]            rd_word;
    logic                   rd_fault;

    assign d_pop = d_valid && (!f_valid || turn_data);
    assign f_pop = f_valid && !d_pop;

    assign ram_wr = s_valid && !s_fault && (s_be != 4'b0000);
    assign ram_rd = s_valid && !s_fault && (s_be == 4'b0000);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            turn_data  <= 1'b1;
            s_valid    <= 1'b0;
            s_data     <= 1'b0;
            f_rd_valid <= 1'b0;
            d_rd_valid <= 1'b0;
        end else begin
            if (f_pop || d_pop) begin
                turn_data <= f_pop;              // Other port next time
            end
            s_valid    <= f_pop || d_pop;
            s_data     <= d_pop;
            f_rd_valid <= s_valid && !s_data;    // Return goes to the owner
            d_rd_valid <= s_valid && s_data;
        end
    end

    // Latch the granted head
    always_ff @(posedge clock) begin
        s_idx   <= d_pop ? d_word_idx : f_word_idx;
        s_be    <= d_pop ? d_be : 4'b0000;       // Fetch never writes
        s_wdata <= d_wdata;
        s_fault <= d_pop ? d_fault : f_fault;
    end

    always_ff @(posedge clock) begin
        if (ram_wr) begin
            if (s_be[0]) begin
                mem_b0[s_idx] <= s_wdata[7:0];
            end
            if (s_be[1]) begin
                mem_b1[s_idx] <= s_wdata[15:8];
            end
            if (s_be[2]) begin
                mem_b2[s_idx] <= s_wdata[23:16];
            end
            if (s_be[3]) begin
                mem_b3[s_idx] <= s_wdata[31:24];
            end
        end
        if (ram_rd) begin
            rd_word <= {mem_b3[s_idx], mem_b2[s_idx], mem_b1[s_idx], mem_b0[s_idx]};
        end
        rd_fault <= s_fault;
    end

    assign f_rd_word  = rd_word;                 // Shared read register
    assign d_rd_word  = rd_word;
    assign f_rd_fault = rd_fault;
    assign d_rd_fault = rd_fault;

endmodule

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
/*
 * Memory subsystem top: fetch port, load/store port, shared RAM.
 * Both request channels use credits, QUEUE_DEPTH each after reset.
 * Responses have no back-pressure and arrive in order per port.
 */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        fetch_valid,
    input  logic [31:0] fetch_addr,
    output logic        fetch_credit,
    output logic        fetch_rsp_valid,
    output logic [31:0] fetch_rsp_data,
    output logic        fetch_rsp_fault,
    input  logic        data_valid,
    input  logic        data_we,
    input  logic [2:0]  data_funct3,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic        data_credit,
    output logic        data_rsp_valid,
    output logic [31:0] data_rsp_rdata,
    output logic        data_rsp_fault
);
    import mem_pkg::*;

    logic                   f_valid;             // Fetch queue head
    logic [WORD_ADDR_W-1:0] f_word_idx;
    logic                   f_fault;
    logic                   f_pop;
    logic                   d_valid;             // Data queue head
    logic [WORD_ADDR_W-1:0] d_word_idx;
    logic [3:0]             d_be;
    logic [31:0]            d_wdata;
    logic                   d_fault;
    logic                   d_pop;
    logic                   f_rd_valid;          // RAM returns
    logic [31:0]            f_rd_word;
    logic                   f_rd_fault;
    logic                   d_rd_valid;
    logic [31:0]            d_rd_word;
    logic                   d_rd_fault;

    fetch_port u_fetch (
        .clock           (clock),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_addr      (fetch_addr),
        .fetch_credit    (fetch_credit),
        .q_valid         (f_valid),
        .q_word_idx      (f_word_idx),
        .q_fault         (f_fault),
        .q_pop           (f_pop),
        .rd_valid        (f_rd_valid),
        .rd_word         (f_rd_word),
        .rd_fault        (f_rd_fault),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_data  (fetch_rsp_data),
        .fetch_rsp_fault (fetch_rsp_fault)
    );

    lsu_port u_lsu (
        .clock          (clock),
        .rst_n          (rst_n),
        .data_valid     (data_valid),
        .data_we        (data_we),
        .data_funct3    (data_funct3),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .data_credit    (data_credit),
        .q_valid        (d_valid),
        .q_word_idx     (d_word_idx),
        .q_be           (d_be),
        .q_wdata        (d_wdata),
        .q_fault        (d_fault),
        .q_pop          (d_pop),
        .rd_valid       (d_rd_valid),
        .rd_word        (d_rd_word),
        .rd_fault       (d_rd_fault),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp_rdata (data_rsp_rdata),
        .data_rsp_fault (data_rsp_fault)
    );

    mem_arbiter_ram u_mem (
        .clock      (clock),
        .rst_n      (rst_n),
        .f_valid    (f_valid),
        .f_word_idx (f_word_idx),
        .f_fault    (f_fault),
        .d_valid    (d_valid),
        .d_word_idx (d_word_idx),
        .d_be       (d_be),
        .d_wdata    (d_wdata),
        .d_fault    (d_fault),
        .f_pop      (f_pop),
        .d_pop      (d_pop),
        .f_rd_valid (f_rd_valid),
        .f_rd_word  (f_rd_word),
        .f_rd_fault (f_rd_fault),
        .d_rd_valid (d_rd_valid),
        .d_rd_word  (d_rd_word),
        .d_rd_fault (d_rd_fault)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_mem_subsys.sv ====
/*
 * Table-driven testbench for mem_subsys_top.
 * Rows on different ports may issue in the same cycle. A sync row waits for
 * all earlier responses, so a fetch can see data stored through the data port.
 * Only words written earlier in the table are read back.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int ROW_CYCLES = 40;               // Watchdog budget per row
    localparam bit FETCH      = 1'b0;
    localparam bit DATA       = 1'b1;

    typedef struct packed {
        logic        port;
        logic        sync;                        // Wait until all responses are back
        logic        we;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_fault;
    } row_t;

    logic        clock;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_credit;
    logic        fetch_rsp_valid;
    logic [31:0] fetch_rsp_data;
    logic        fetch_rsp_fault;
    logic        data_valid;
    logic        data_we;
    logic [2:0]  data_funct3;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_credit;
    logic        data_rsp_valid;
    logic [31:0] data_rsp_rdata;
    logic        data_rsp_fault;

    row_t        rows[$];
    logic [32:0] exp_fetch_q[$];                  // {fault, data} in issue order
    logic [32:0] exp_data_q[$];
    int          fetch_credits;                   // Credits held by the requester
    int          data_credits;
    logic [31:0] lfsr_state;
    logic        table_ready;

    mem_subsys_top DUT (
        .clock           (clock),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_addr      (fetch_addr),
        .fetch_credit    (fetch_credit),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp_data  (fetch_rsp_data),
        .fetch_rsp_fault (fetch_rsp_fault),
        .data_valid      (data_valid),
        .data_we         (data_we),
        .data_funct3     (data_funct3),
        .data_addr       (data_addr),
        .data_wdata      (data_wdata),
        .data_credit     (data_credit),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp_rdata  (data_rsp_rdata),
        .data_rsp_fault  (data_rsp_fault)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            gap = (gap << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check(input string what, input logic [32:0] actual,
                         input logic [32:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic add_row(input logic port, input logic sync, input logic we,
                           input logic [2:0] funct3, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp_rdata,
                           input logic exp_fault);
        rows.push_back({port, sync, we, funct3, addr, wdata, exp_rdata, exp_fault});
    endtask

    // Advance to the next falling edge, account credits, check responses
    task automatic next_cycle();
        @(negedge clock);
        if (fetch_valid) fetch_credits--;         // Accepted at the last rising edge
        if (fetch_credit) fetch_credits++;
        if (data_valid) data_credits--;
        if (data_credit) data_credits++;
        if (fetch_credits > QUEUE_DEPTH || data_credits > QUEUE_DEPTH) begin
            fail_run("more credits came back than requests were issued");
        end
        if (fetch_rsp_valid) begin
            if (exp_fetch_q.size() == 0) begin
                fail_run("fetch response arrived with no request outstanding");
            end else begin
                check("fetch response", {fetch_rsp_fault, fetch_rsp_data},
                      exp_fetch_q.pop_front());
            end
        end
        if (data_rsp_valid) begin
            if (exp_data_q.size() == 0) begin
                fail_run("data response arrived with no request outstanding");
            end else begin
                check("data response", {data_rsp_fault, data_rsp_rdata},
                      exp_data_q.pop_front());
            end
        end
        fetch_valid = 1'b0;                       // Valid lasts one cycle
        data_valid  = 1'b0;
    endtask

    function automatic bit can_issue(input row_t r);
        if (r.sync && (exp_fetch_q.size() != 0 || exp_data_q.size() != 0)) return 1'b0;
        if (r.port == FETCH) return !fetch_valid && fetch_credits > 0;
        return !data_valid && data_credits > 0;
    endfunction

    task automatic issue_row(input row_t r);
        if (r.port == FETCH) begin
            fetch_valid = 1'b1;
            fetch_addr  = r.addr;
            exp_fetch_q.push_back({r.exp_fault, r.exp_rdata});
        end else begin
            data_valid  = 1'b1;
            data_we     = r.we;
            data_funct3 = r.funct3;
            data_addr   = r.addr;
            data_wdata  = r.wdata;
            exp_data_q.push_back({r.exp_fault, r.exp_rdata});
        end
    endtask

    task automatic build_table();
        // Word stores followed by fetches of the same words
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0000, 32'h0BAD_F00D, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0100, 32'h1234_5678, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0104, 32'hCAFE_F00D, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0108, 32'h8081_7F01, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_3FFC, 32'hA5A5_5A5A, 32'h0, 1'b0);
        add_row(FETCH, 1'b1, 1'b0, F3_LW,  32'h0000_0100, 32'h0, 32'h1234_5678, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0104, 32'h0, 32'hCAFE_F00D, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_3FFC, 32'h0, 32'hA5A5_5A5A, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0000, 32'h0, 32'h0BAD_F00D, 1'b0);
        // Bytes of 0x108 from lane 0 up are 01 7F 81 80
        add_row(DATA,  1'b0, 1'b0, F3_LB,  32'h0000_0108, 32'h0, 32'h0000_0001, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LB,  32'h0000_0109, 32'h0, 32'h0000_007F, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LB,  32'h0000_010A, 32'h0, 32'hFFFF_FF81, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LB,  32'h0000_010B, 32'h0, 32'hFFFF_FF80, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'h0000_0108, 32'h0, 32'h0000_0001, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'h0000_0109, 32'h0, 32'h0000_007F, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'h0000_010A, 32'h0, 32'h0000_0081, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'h0000_010B, 32'h0, 32'h0000_0080, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LH,  32'h0000_0108, 32'h0, 32'h0000_7F01, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LH,  32'h0000_010A, 32'h0, 32'hFFFF_8081, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LHU, 32'h0000_0108, 32'h0, 32'h0000_7F01, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LHU, 32'h0000_010A, 32'h0, 32'h0000_8081, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0108, 32'h0, 32'h8081_7F01, 1'b0);
        // Sub-word stores merge into 0x110
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0110, 32'h1122_3344, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SB,  32'h0000_0111, 32'h0000_00AB, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SH,  32'h0000_0112, 32'h0000_BEEF, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SB,  32'h0000_0110, 32'hFFFF_FF5C, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0110, 32'h0, 32'hBEEF_AB5C, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SB,  32'h0000_0113, 32'h0000_0077, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SH,  32'h0000_0110, 32'h0000_1357, 32'h0, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0110, 32'h0, 32'h77EF_1357, 1'b0);
        add_row(FETCH, 1'b1, 1'b0, F3_LW,  32'h0000_0110, 32'h0, 32'h77EF_1357, 1'b0);
        // Misaligned and out-of-range accesses fault and leave memory alone
        add_row(DATA,  1'b0, 1'b0, F3_LH,  32'h0000_0109, 32'h0, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_010A, 32'h0, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0102, 32'hDEAD_BEEF, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b1, F3_SH,  32'h0000_0103, 32'h0000_FFFF, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0100, 32'h0, 32'h1234_5678, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_4000, 32'hFFFF_FFFF, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0000, 32'h0, 32'h0BAD_F00D, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LB,  32'h0000_4000, 32'h0, 32'h0, 1'b1);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'hFFFF_FFFF, 32'h0, 32'h0, 1'b1);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_4000, 32'h0, 32'h0, 1'b1);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0102, 32'h0, 32'h0, 1'b1);
        // Both ports together while fetches avoid the words being written
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0200, 32'h0F1E_2D3C, 32'h0, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0100, 32'h0, 32'h1234_5678, 1'b0);
        add_row(DATA,  1'b0, 1'b1, F3_SW,  32'h0000_0204, 32'h4B5A_6978, 32'h0, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0104, 32'h0, 32'hCAFE_F00D, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0200, 32'h0, 32'h0F1E_2D3C, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0108, 32'h0, 32'h8081_7F01, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LH,  32'h0000_0206, 32'h0, 32'h0000_4B5A, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0110, 32'h0, 32'h77EF_1357, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LBU, 32'h0000_0201, 32'h0, 32'h0000_002D, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_3FFC, 32'h0, 32'hA5A5_5A5A, 1'b0);
        add_row(DATA,  1'b0, 1'b0, F3_LW,  32'h0000_0204, 32'h0, 32'h4B5A_6978, 1'b0);
        add_row(FETCH, 1'b0, 1'b0, F3_LW,  32'h0000_0000, 32'h0, 32'h0BAD_F00D, 1'b0);
    endtask

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (ROW_CYCLES * rows.size() + 10));
        fail_run("timeout: responses or credits did not come back in time");
    end

    initial begin
        int   gap;
        row_t r;
        fetch_valid   = 1'b0;
        fetch_addr    = 32'd0;
        data_valid    = 1'b0;
        data_we       = 1'b0;
        data_funct3   = 3'd0;
        data_addr     = 32'd0;
        data_wdata    = 32'd0;
        rst_n         = 1'b0;
        lfsr_state    = 32'h703d4135;
        fetch_credits = QUEUE_DEPTH;
        data_credits  = QUEUE_DEPTH;
        build_table();
        table_ready   = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            r = rows[i];
            draw_gap(gap);                        // 0 to 3 idle cycles
            repeat (gap) next_cycle();
            while (!can_issue(r)) next_cycle();
            issue_row(r);
        end
        next_cycle();
        while (exp_fetch_q.size() != 0 || exp_data_q.size() != 0) next_cycle();
        // Credits return before the matching response
        check("fetch credits after drain", 33'(fetch_credits), 33'(QUEUE_DEPTH));
        check("data credits after drain", 33'(data_credits), 33'(QUEUE_DEPTH));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
common/mem_pkg.sv
hw/req_queue.sv
hw/fetch_port.sv
hw/lsu_port.sv
hw/mem_arbiter_ram.sv
hw/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f files.f --top-module tb_mem_subsys -Mdir obj_dir -o sim_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
